// File: source/reg_bus_pkg.sv
package reg_bus_pkg;

    // ------------------------------------------------------------------------
    // bus widths
    // ------------------------------------------------------------------------
    localparam int ADDR_W    = 16;                 // register address width
    localparam int DATA_W    = 32;                 // quadlet data width
    localparam int BW_ADDR_W = 8;                  // block-write address, zero-extended

    // address space, taken from address bits 15:12
    typedef enum logic [3:0] {
        ADDR_MAIN = 4'h0,                          // board registers and channels
        ADDR_HUB  = 4'h2                           // hub quadlet buffer
    } addr_space_e;                                // any other value goes to the external bus

    // channel-0 board register offsets, address bits 3:0
    typedef enum logic [3:0] {
        REG_STATUS  = 4'd0,                        // timeout flag, board id, period
        REG_WDOG    = 4'd3,                        // watchdog period
        REG_VERSION = 4'd7,                        // firmware version
        REG_IPADDR  = 4'd11                        // ip address
    } board_reg_e;

    // which source owns the write bus this cycle
    typedef enum logic [1:0] {
        MASTER_BW  = 2'd0,                         // block-write engine, highest priority
        MASTER_ETH = 2'd1,                         // ethernet
        MASTER_FW  = 2'd2                          // firewire, the default owner
    } bus_master_e;

    localparam logic [DATA_W-1:0] IP_RESET = '1;   // unassigned ip address

endpackage

// File: source/write_arbiter.sv
`timescale 1ns/1ps

module write_arbiter (
    input  logic                             sysclk,
    input  logic                             rst_n,
    // block-write source
    input  logic                             bw_write_en,   // bw owns the bus
    input  logic [reg_bus_pkg::BW_ADDR_W-1:0] bw_reg_waddr,
    input  logic [reg_bus_pkg::DATA_W-1:0]    bw_reg_wdata,
    input  logic                             bw_reg_wen,
    input  logic                             bw_blk_wen,
    input  logic                             bw_blk_wstart,
    // ethernet source
    input  logic                             eth_write_en,  // eth owns the bus
    input  logic [reg_bus_pkg::ADDR_W-1:0]    eth_reg_waddr,
    input  logic [reg_bus_pkg::DATA_W-1:0]    eth_reg_wdata,
    input  logic                             eth_reg_wen,
    input  logic                             eth_blk_wen,
    input  logic                             eth_blk_wstart,
    // firewire source owns the bus when nobody else does
    input  logic [reg_bus_pkg::ADDR_W-1:0]    fw_reg_waddr,
    input  logic [reg_bus_pkg::DATA_W-1:0]    fw_reg_wdata,
    input  logic                             fw_reg_wen,
    input  logic                             fw_blk_wen,
    input  logic                             fw_blk_wstart,
    // shared write bus one cycle after the sources
    output logic [reg_bus_pkg::ADDR_W-1:0]    reg_waddr,
    output logic [reg_bus_pkg::DATA_W-1:0]    reg_wdata,
    output logic                             reg_wen,
    output logic                             blk_wen,
    output logic                             blk_wstart
);

    reg_bus_pkg::bus_master_e         master_sel;  // owner this cycle
    logic [reg_bus_pkg::ADDR_W-1:0]   sel_waddr;
    logic [reg_bus_pkg::DATA_W-1:0]   sel_wdata;
    logic [2:0]                       sel_strobe;  // {reg_wen, blk_wen, blk_wstart}

    always_comb begin
        if (bw_write_en)
            master_sel = reg_bus_pkg::MASTER_BW;
        else if (eth_write_en)
            master_sel = reg_bus_pkg::MASTER_ETH;
        else
            master_sel = reg_bus_pkg::MASTER_FW;
    end

    always_comb begin
        case (master_sel)
            reg_bus_pkg::MASTER_BW: begin
                sel_waddr  = {{(reg_bus_pkg::ADDR_W - reg_bus_pkg::BW_ADDR_W){1'b0}},
                              bw_reg_waddr};      // short address with upper bits zero
                sel_wdata  = bw_reg_wdata;
                sel_strobe = {bw_reg_wen, bw_blk_wen, bw_blk_wstart};
            end
            reg_bus_pkg::MASTER_ETH: begin
                sel_waddr  = eth_reg_waddr;
                sel_wdata  = eth_reg_wdata;
                sel_strobe = {eth_reg_wen, eth_blk_wen, eth_blk_wstart};
            end
            default: begin
                sel_waddr  = fw_reg_waddr;
                sel_wdata  = fw_reg_wdata;
                sel_strobe = {fw_reg_wen, fw_blk_wen, fw_blk_wstart};
            end
        endcase
    end

    // selected master registered onto the shared bus
    always_ff @(posedge sysclk) begin
        reg_waddr <= sel_waddr;
        reg_wdata <= sel_wdata;
        if (!rst_n) begin
            {reg_wen, blk_wen, blk_wstart} <= 3'b000;
        end else begin
            {reg_wen, blk_wen, blk_wstart} <= sel_strobe;
        end
    end

endmodule

// File: source/hub_buffer.sv
`timescale 1ns/1ps

module hub_buffer #(
    parameter int HUB_DEPTH_LOG2 = 6                 // log2 of entry count
) (
    input  logic                           sysclk,
    input  logic                           rst_n,
    // write bus
    input  logic                           reg_wen,
    input  logic [reg_bus_pkg::ADDR_W-1:0] reg_waddr,
    input  logic [reg_bus_pkg::DATA_W-1:0] reg_wdata,
    // read side
    input  logic [reg_bus_pkg::ADDR_W-1:0] reg_raddr,
    output logic [reg_bus_pkg::DATA_W-1:0] hub_rdata  // zero for unwritten entries
);

    localparam int DEPTH = 1 << HUB_DEPTH_LOG2;

    logic [reg_bus_pkg::DATA_W-1:0] mem [DEPTH];     // quadlet storage
    logic [DEPTH-1:0]               valid;           // one flag per entry
    logic [HUB_DEPTH_LOG2-1:0]      widx;
    logic [HUB_DEPTH_LOG2-1:0]      ridx;
    logic                           hub_wr;          // write lands in hub space

    assign widx   = reg_waddr[HUB_DEPTH_LOG2-1:0];
    assign ridx   = reg_raddr[HUB_DEPTH_LOG2-1:0];
    assign hub_wr = reg_wen && (reg_waddr[15:12] == reg_bus_pkg::ADDR_HUB);

    // ------------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (hub_wr)
            mem[widx] <= reg_wdata;
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            valid <= '0;                             // buffer starts empty
        end else if (hub_wr) begin
            valid[widx] <= 1'b1;
        end
    end

    // combinational read, the router registers it
    assign hub_rdata = valid[ridx] ? mem[ridx] : '0;

endmodule

// File: source/board_regs.sv
`timescale 1ns/1ps

module board_regs #(
    parameter int          WDOG_TICK  = 16,           // cycles per watchdog count
    parameter logic [31:0] FW_VERSION = 32'h0000_0700 // version register contents
) (
    input  logic                           sysclk,
    input  logic                           rst_n,
    input  logic [3:0]                     board_id,    // rotary switch
    // write bus
    input  logic                           reg_wen,
    input  logic [reg_bus_pkg::ADDR_W-1:0] reg_waddr,
    input  logic [reg_bus_pkg::DATA_W-1:0] reg_wdata,
    // read side
    input  logic [reg_bus_pkg::ADDR_W-1:0] reg_raddr,
    output logic [reg_bus_pkg::DATA_W-1:0] chan0_rdata,
    output logic                           chan0_hit,   // offset implemented here
    // watchdog
    input  logic                           wdog_clear,  // host clears the flag
    output logic                           wdog_timeout
);

    localparam int PRE_W = $clog2(WDOG_TICK + 1);

    logic [reg_bus_pkg::DATA_W-1:0] ip_address;
    logic [15:0]                    wdog_period;      // 0 disables the watchdog
    logic [15:0]                    wdog_count;       // ticks since last restart
    logic [PRE_W-1:0]               wdog_presc;       // cycles within one tick
    logic                           wdog_tick;
    logic                           board_wr;         // any channel-0 write

    assign board_wr = reg_wen && (reg_waddr[15:12] == reg_bus_pkg::ADDR_MAIN)
                      && (reg_waddr[7:4] == 4'd0);

    // ------------------------------------------------------------------------
    // writable registers
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            ip_address  <= reg_bus_pkg::IP_RESET;
            wdog_period <= 16'd0;                     // watchdog off
        end else if (board_wr) begin
            case (reg_waddr[3:0])
                reg_bus_pkg::REG_IPADDR: ip_address  <= reg_wdata;
                reg_bus_pkg::REG_WDOG:   wdog_period <= reg_wdata[15:0];
                default: ;                            // read-only or unclaimed
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------------------
    assign wdog_tick = (wdog_presc == PRE_W'(WDOG_TICK - 1));

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wdog_presc   <= '0;
            wdog_count   <= 16'd0;
            wdog_timeout <= 1'b0;
        end else if (board_wr || wdog_clear) begin
            wdog_presc   <= '0;                       // host activity restarts the count
            wdog_count   <= 16'd0;
            wdog_timeout <= 1'b0;
        end else if (wdog_period != 16'd0) begin
            wdog_presc <= wdog_tick ? '0 : wdog_presc + 1'b1;
            if (wdog_tick && (wdog_count != wdog_period))
                wdog_count <= wdog_count + 16'd1;     // saturates at the period
            if (wdog_count == wdog_period)
                wdog_timeout <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // read mux
    // ------------------------------------------------------------------------
    always_comb begin
        chan0_hit   = 1'b1;
        chan0_rdata = '0;
        case (reg_raddr[3:0])
            reg_bus_pkg::REG_STATUS:
                chan0_rdata = {wdog_timeout, 3'd0, board_id, 8'd0, wdog_period};
            reg_bus_pkg::REG_VERSION: chan0_rdata = FW_VERSION;
            reg_bus_pkg::REG_IPADDR:  chan0_rdata = ip_address;
            reg_bus_pkg::REG_WDOG:    chan0_rdata = {16'd0, wdog_period};
            default: chan0_hit = 1'b0;                // external board answers
        endcase
    end

endmodule

// File: source/read_router.sv
`timescale 1ns/1ps

module read_router (
    input  logic                           sysclk,
    input  logic                           rst_n,
    // sampler
    input  logic                           sample_busy,     // sampler owns reg_raddr
    input  logic [3:0]                     sample_chan,
    // read address sources
    input  logic                           eth_read_en,     // eth read in progress
    input  logic [reg_bus_pkg::ADDR_W-1:0] eth_reg_raddr,
    input  logic [reg_bus_pkg::ADDR_W-1:0] fw_reg_raddr,
    // sample start requests
    input  logic                           eth_sample_start,
    input  logic                           fw_sample_start,
    // read data from the targets
    input  logic [reg_bus_pkg::DATA_W-1:0] hub_rdata,
    input  logic [reg_bus_pkg::DATA_W-1:0] chan0_rdata,
    input  logic                           chan0_hit,
    input  logic [reg_bus_pkg::DATA_W-1:0] reg_rdata_ext,   // external board
    // read bus
    output logic [reg_bus_pkg::ADDR_W-1:0] reg_raddr,
    output logic [reg_bus_pkg::DATA_W-1:0] reg_rdata,       // one cycle after reg_raddr
    output logic                           sample_start
);

    logic [3:0]                     raddr_space;
    logic                           is_chan0;               // main space, channel 0
    logic [reg_bus_pkg::DATA_W-1:0] rdata_sel;

    // ------------------------------------------------------------------------
    // address override and sampling
    // ------------------------------------------------------------------------
    assign reg_raddr = sample_busy ? {reg_bus_pkg::ADDR_MAIN, 4'd0, sample_chan, 4'd0} :
                       eth_read_en ? eth_reg_raddr :
                       fw_reg_raddr;

    // only one host is expected to start sampling at a time
    assign sample_start = (eth_sample_start | fw_sample_start) & ~sample_busy;

    // ------------------------------------------------------------------------
    // read data routing
    // ------------------------------------------------------------------------
    assign raddr_space = reg_raddr[15:12];
    assign is_chan0    = (raddr_space == reg_bus_pkg::ADDR_MAIN) && (reg_raddr[7:4] == 4'd0);

    always_comb begin
        if (raddr_space == reg_bus_pkg::ADDR_HUB)
            rdata_sel = hub_rdata;
        else if (is_chan0 && chan0_hit)
            rdata_sel = chan0_rdata;
        else
            rdata_sel = reg_rdata_ext;                      // everything unclaimed
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rdata_sel;
        end
    end

endmodule

// File: source/reg_bus_top.sv
`timescale 1ns/1ps

module reg_bus_top #(
    parameter int          HUB_DEPTH_LOG2 = 6,
    parameter int          WDOG_TICK      = 16,
    parameter logic [31:0] FW_VERSION     = 32'h0000_0700
) (
    input  logic                              sysclk,
    input  logic                              rst_n,
    // block-write source
    input  logic                              bw_write_en,
    input  logic [reg_bus_pkg::BW_ADDR_W-1:0] bw_reg_waddr,
    input  logic [reg_bus_pkg::DATA_W-1:0]    bw_reg_wdata,
    input  logic                              bw_reg_wen,
    input  logic                              bw_blk_wen,
    input  logic                              bw_blk_wstart,
    // ethernet source
    input  logic                              eth_write_en,
    input  logic [reg_bus_pkg::ADDR_W-1:0]    eth_reg_waddr,
    input  logic [reg_bus_pkg::DATA_W-1:0]    eth_reg_wdata,
    input  logic                              eth_reg_wen,
    input  logic                              eth_blk_wen,
    input  logic                              eth_blk_wstart,
    input  logic                              eth_read_en,
    input  logic [reg_bus_pkg::ADDR_W-1:0]    eth_reg_raddr,
    input  logic                              eth_sample_start,
    // firewire source
    input  logic [reg_bus_pkg::ADDR_W-1:0]    fw_reg_waddr,
    input  logic [reg_bus_pkg::DATA_W-1:0]    fw_reg_wdata,
    input  logic                              fw_reg_wen,
    input  logic                              fw_blk_wen,
    input  logic                              fw_blk_wstart,
    input  logic [reg_bus_pkg::ADDR_W-1:0]    fw_reg_raddr,
    input  logic                              fw_sample_start,
    // sampler, board and external bus
    input  logic                              sample_busy,
    input  logic [3:0]                        sample_chan,
    input  logic [3:0]                        board_id,
    input  logic [reg_bus_pkg::DATA_W-1:0]    reg_rdata_ext,
    input  logic                              wdog_clear,
    // write bus
    output logic [reg_bus_pkg::ADDR_W-1:0]    reg_waddr,
    output logic [reg_bus_pkg::DATA_W-1:0]    reg_wdata,
    output logic                              reg_wen,
    output logic                              blk_wen,
    output logic                              blk_wstart,
    // read bus
    output logic [reg_bus_pkg::ADDR_W-1:0]    reg_raddr,
    output logic [reg_bus_pkg::DATA_W-1:0]    reg_rdata,
    output logic                              sample_start,
    output logic                              wdog_timeout
);

    logic [reg_bus_pkg::DATA_W-1:0] hub_rdata;      // hub space read data
    logic [reg_bus_pkg::DATA_W-1:0] chan0_rdata;    // board register read data
    logic                           chan0_hit;

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------
    write_arbiter i_write_arbiter (
        .sysclk(sysclk), .rst_n(rst_n),
        .bw_write_en(bw_write_en), .bw_reg_waddr(bw_reg_waddr),
        .bw_reg_wdata(bw_reg_wdata), .bw_reg_wen(bw_reg_wen),
        .bw_blk_wen(bw_blk_wen), .bw_blk_wstart(bw_blk_wstart),
        .eth_write_en(eth_write_en), .eth_reg_waddr(eth_reg_waddr),
        .eth_reg_wdata(eth_reg_wdata), .eth_reg_wen(eth_reg_wen),
        .eth_blk_wen(eth_blk_wen), .eth_blk_wstart(eth_blk_wstart),
        .fw_reg_waddr(fw_reg_waddr), .fw_reg_wdata(fw_reg_wdata),
        .fw_reg_wen(fw_reg_wen), .fw_blk_wen(fw_blk_wen), .fw_blk_wstart(fw_blk_wstart),
        .reg_waddr(reg_waddr), .reg_wdata(reg_wdata), .reg_wen(reg_wen),
        .blk_wen(blk_wen), .blk_wstart(blk_wstart)
    );

    // ------------------------------------------------------------------------
    // write targets
    // ------------------------------------------------------------------------
    hub_buffer #(.HUB_DEPTH_LOG2(HUB_DEPTH_LOG2)) i_hub_buffer (
        .sysclk(sysclk), .rst_n(rst_n),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_raddr(reg_raddr), .hub_rdata(hub_rdata)
    );

    board_regs #(.WDOG_TICK(WDOG_TICK), .FW_VERSION(FW_VERSION)) i_board_regs (
        .sysclk(sysclk), .rst_n(rst_n), .board_id(board_id),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_raddr(reg_raddr), .chan0_rdata(chan0_rdata), .chan0_hit(chan0_hit),
        .wdog_clear(wdog_clear), .wdog_timeout(wdog_timeout)
    );

    // read address and data return
    read_router i_read_router (
        .sysclk(sysclk), .rst_n(rst_n),
        .sample_busy(sample_busy), .sample_chan(sample_chan),
        .eth_read_en(eth_read_en), .eth_reg_raddr(eth_reg_raddr),
        .fw_reg_raddr(fw_reg_raddr),
        .eth_sample_start(eth_sample_start), .fw_sample_start(fw_sample_start),
        .hub_rdata(hub_rdata), .chan0_rdata(chan0_rdata), .chan0_hit(chan0_hit),
        .reg_rdata_ext(reg_rdata_ext),
        .reg_raddr(reg_raddr), .reg_rdata(reg_rdata), .sample_start(sample_start)
    );

endmodule

// File: tests/tb_reg_bus.sv
`timescale 1ns/1ps

module tb_reg_bus;

    logic        sysclk, rst_n;
    logic        bw_write_en, bw_reg_wen, bw_blk_wen, bw_blk_wstart;
    logic [7:0]  bw_reg_waddr;                              // short block-write address
    logic [31:0] bw_reg_wdata;
    logic        eth_write_en, eth_reg_wen, eth_blk_wen, eth_blk_wstart;
    logic        eth_read_en, eth_sample_start;
    logic [15:0] eth_reg_waddr, eth_reg_raddr;
    logic [31:0] eth_reg_wdata;
    logic        fw_reg_wen, fw_blk_wen, fw_blk_wstart, fw_sample_start;
    logic [15:0] fw_reg_waddr, fw_reg_raddr;
    logic [31:0] fw_reg_wdata;
    logic        sample_busy, wdog_clear;
    logic [3:0]  sample_chan, board_id;
    logic [31:0] reg_rdata_ext;                             // external board read data
    logic [15:0] reg_waddr, reg_raddr;                      // dut outputs from here
    logic [31:0] reg_wdata, reg_rdata;
    logic        reg_wen, blk_wen, blk_wstart, sample_start, wdog_timeout;

    logic [31:0] hub_mem [64];                              // model of the hub buffer
    logic [63:0] hub_valid;
    logic [31:0] ip_m;                                      // model ip address
    logic [15:0] period_m;                                  // model watchdog period
    logic [15:0] exp_waddr;                                 // bus expected at next negedge
    logic [31:0] exp_wdata, exp_rdata;
    logic [2:0]  exp_strobe;                                // {reg_wen, blk_wen, blk_wstart}
    logic [31:0] lfsr = 32'hadcb_a7d7;
    int          err_cnt, chk_cnt, err_mark;

    reg_bus_top #(.HUB_DEPTH_LOG2(6), .WDOG_TICK(4)) i_dut (.*);

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;                       // 20 ns period
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    // mix of hub, external, channel-0 and other-channel addresses
    function automatic logic [15:0] rand_raddr();
        logic [1:0] kind;
        kind = 2'(rand_bits(2));
        case (kind)
            2'd0:    return {4'h2, 12'(rand_bits(12))};
            2'd1:    return {1'b1, 3'(rand_bits(3)), 12'(rand_bits(12))};
            2'd2:    return {4'h0, 4'(rand_bits(4)), 4'h0, 4'(rand_bits(4))};
            default: return {4'h0, 12'(rand_bits(12))};
        endcase
    endfunction

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        chk_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("[ERROR] time %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] model_read(input logic [15:0] a);
        if (a[15:12] == 4'h2)                               // hub space
            return hub_valid[a[5:0]] ? hub_mem[a[5:0]] : 32'h0;
        if (a[15:12] == 4'h0 && a[7:4] == 4'h0) begin       // channel 0
            case (a[3:0])
                4'd0:    return {4'h0, board_id, 8'h00, period_m};  // flag low here
                4'd3:    return {16'h0, period_m};
                4'd7:    return 32'h0000_0700;              // default version
                4'd11:   return ip_m;
                default: ;                                  // falls to external
            endcase
        end
        return reg_rdata_ext;
    endfunction

    task automatic predict();
        logic [15:0] ra;
        ra = sample_busy ? {8'h00, sample_chan, 4'h0} : eth_read_en ? eth_reg_raddr : fw_reg_raddr;
        compare(32'(reg_raddr), 32'(ra), "reg_raddr");
        compare(32'(sample_start), 32'((eth_sample_start | fw_sample_start) & ~sample_busy),
                "sample_start");
        exp_rdata = model_read(ra);                         // state before this cycle's write
        if (exp_strobe[2]) begin                            // bus write lands at next edge
            if (exp_waddr[15:12] == 4'h2) begin
                hub_mem[exp_waddr[5:0]]   = exp_wdata;
                hub_valid[exp_waddr[5:0]] = 1'b1;
            end else if (exp_waddr[15:12] == 4'h0 && exp_waddr[7:4] == 4'h0) begin
                if (exp_waddr[3:0] == 4'd11)
                    ip_m = exp_wdata;
                if (exp_waddr[3:0] == 4'd3)
                    period_m = exp_wdata[15:0];
            end
        end
        if (bw_write_en) begin                              // fixed priority bw, eth, fw
            exp_waddr  = {8'h00, bw_reg_waddr};
            exp_wdata  = bw_reg_wdata;
            exp_strobe = {bw_reg_wen, bw_blk_wen, bw_blk_wstart};
        end else if (eth_write_en) begin
            exp_waddr  = eth_reg_waddr;
            exp_wdata  = eth_reg_wdata;
            exp_strobe = {eth_reg_wen, eth_blk_wen, eth_blk_wstart};
        end else begin
            exp_waddr  = fw_reg_waddr;
            exp_wdata  = fw_reg_wdata;
            exp_strobe = {fw_reg_wen, fw_blk_wen, fw_blk_wstart};
        end
    endtask

    // one clock, outputs checked at the falling edge
    task automatic clock_cycle();
        @(negedge sysclk);
        compare(32'(reg_waddr), 32'(exp_waddr), "reg_waddr");
        compare(reg_wdata, exp_wdata, "reg_wdata");
        compare(32'({reg_wen, blk_wen, blk_wstart}), 32'(exp_strobe), "write strobes");
        compare(reg_rdata, exp_rdata, "reg_rdata");
        predict();
    endtask

    task automatic quiet_inputs();
        @(posedge sysclk);
        {bw_write_en, bw_reg_wen, bw_blk_wen, bw_blk_wstart} <= 4'h0;
        {eth_write_en, eth_reg_wen, eth_blk_wen, eth_blk_wstart} <= 4'h0;
        {fw_reg_wen, fw_blk_wen, fw_blk_wstart} <= 3'h0;
        {eth_read_en, sample_busy, eth_sample_start, fw_sample_start, wdog_clear} <= 5'h0;
        fw_reg_raddr <= 16'h1000;                           // park on external space
        clock_cycle();
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [31:0] d);
        @(posedge sysclk);
        eth_write_en  <= 1'b1;
        eth_reg_waddr <= a;
        eth_reg_wdata <= d;
        eth_reg_wen   <= 1'b1;
        clock_cycle();
        @(posedge sysclk);
        eth_write_en  <= 1'b0;
        eth_reg_wen   <= 1'b0;
        clock_cycle();                                      // write now on the bus
    endtask

    task automatic read_expect(input logic [15:0] a, input logic [31:0] value, input string what);
        @(posedge sysclk);
        fw_reg_raddr <= a;
        clock_cycle();                                      // address out
        clock_cycle();                                      // data registered
        compare(reg_rdata, value, what);
    endtask

    task automatic wait_rise();
        int n;
        n = 0;
        while (!wdog_timeout && n < 40) begin
            clock_cycle();
            n++;
        end
        if (!wdog_timeout) begin
            err_cnt++;
            $display("watchdog flag did not rise within 40 cycles of the last board write");
        end else begin
            compare(32'(n >= 16 && n <= 24), 32'd1, "watchdog rise inside 16 to 24 cycles");
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-9s finished with %0d errors", name, err_cnt - err_mark);
        err_mark = err_cnt;
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        {bw_write_en, bw_reg_wen, bw_blk_wen, bw_blk_wstart, bw_reg_waddr, bw_reg_wdata} = '0;
        {eth_write_en, eth_reg_wen, eth_blk_wen, eth_blk_wstart, eth_read_en} = '0;
        {eth_sample_start, eth_reg_waddr, eth_reg_raddr, eth_reg_wdata} = '0;
        {fw_reg_wen, fw_blk_wen, fw_blk_wstart, fw_sample_start} = '0;
        {fw_reg_waddr, fw_reg_raddr, fw_reg_wdata} = '0;
        {sample_busy, wdog_clear, sample_chan, board_id, reg_rdata_ext} = '0;
        rst_n      = 1'b0;
        hub_valid  = '0;                                    // model starts empty too
        ip_m       = 32'hffff_ffff;
        period_m   = 16'h0;
        exp_strobe = 3'h0;
        repeat (4) @(posedge sysclk);
        rst_n <= 1'b1;
        @(negedge sysclk);
        compare(32'({reg_wen, blk_wen, blk_wstart}), 32'h0, "strobes after reset");
        compare(32'(wdog_timeout), 32'h0, "wdog_timeout after reset");
        compare(reg_rdata, 32'h0, "reg_rdata after reset");
        predict();
        read_expect(16'h2005, 32'h0, "hub entry after reset");
        read_expect(16'h000b, 32'hffff_ffff, "ip address after reset");
        read_expect(16'h0007, 32'h0000_0700, "version register");
        end_test("reset");

        repeat (300) begin                                  // overlapping masters
            @(posedge sysclk);
            bw_write_en   <= 1'(rand_bits(1));
            bw_reg_waddr  <= 8'(rand_bits(8));
            bw_reg_wdata  <= rand_bits(32);
            {bw_reg_wen, bw_blk_wen, bw_blk_wstart} <= 3'(rand_bits(3));
            eth_write_en  <= 1'(rand_bits(1));
            eth_reg_waddr <= 16'(rand_bits(16));
            eth_reg_wdata <= rand_bits(32);
            {eth_reg_wen, eth_blk_wen, eth_blk_wstart} <= 3'(rand_bits(3));
            fw_reg_waddr  <= 16'(rand_bits(16));
            fw_reg_wdata  <= rand_bits(32);
            {fw_reg_wen, fw_blk_wen, fw_blk_wstart} <= 3'(rand_bits(3));
            fw_reg_raddr  <= {4'h2, 12'(rand_bits(12))};    // hub reads only, no status
            clock_cycle();
        end
        quiet_inputs();
        end_test("priority");

        repeat (200) begin                                  // back-to-back hub traffic
            @(posedge sysclk);
            eth_write_en  <= 1'b1;
            eth_reg_wen   <= 1'(rand_bits(1));
            eth_reg_waddr <= {4'h2, 12'(rand_bits(12))};
            eth_reg_wdata <= rand_bits(32);
            fw_reg_raddr  <= {4'h2, 12'(rand_bits(12))};
            clock_cycle();
        end
        quiet_inputs();
        end_test("hub");

        bus_write(16'h0003, 32'h0);                         // watchdog off, flag cleared
        bus_write(16'h000b, rand_bits(32));
        repeat (200) begin
            @(posedge sysclk);
            eth_read_en   <= 1'(rand_bits(1));
            eth_reg_raddr <= rand_raddr();
            fw_reg_raddr  <= rand_raddr();
            reg_rdata_ext <= rand_bits(32);
            board_id      <= 4'(rand_bits(4));
            clock_cycle();
        end
        quiet_inputs();
        end_test("routing");

        repeat (150) begin
            @(posedge sysclk);
            sample_busy      <= 1'(rand_bits(1));
            sample_chan      <= 4'(rand_bits(4));
            eth_sample_start <= 1'(rand_bits(1));
            fw_sample_start  <= 1'(rand_bits(1));
            fw_reg_raddr     <= rand_raddr();
            reg_rdata_ext    <= rand_bits(32);
            clock_cycle();
        end
        quiet_inputs();
        end_test("sampling");

        bus_write(16'h0003, 32'd5);                         // period of 5 ticks
        wait_rise();
        bus_write(16'h000b, 32'h0a00_0001);                 // any board write restarts it
        clock_cycle();
        compare(32'(wdog_timeout), 32'h0, "wdog_timeout after board write");
        wait_rise();
        @(posedge sysclk);
        wdog_clear <= 1'b1;
        clock_cycle();
        @(posedge sysclk);
        wdog_clear <= 1'b0;
        clock_cycle();
        compare(32'(wdog_timeout), 32'h0, "wdog_timeout after wdog_clear");
        bus_write(16'h0003, 32'h0);
        repeat (200) begin
            clock_cycle();
            compare(32'(wdog_timeout), 32'h0, "wdog_timeout with period 0");
        end
        end_test("watchdog");

        $display("%0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: verilog.f
source/reg_bus_pkg.sv
source/write_arbiter.sv
source/hub_buffer.sv
source/board_regs.sv
source/read_router.sv
source/reg_bus_top.sv
tests/tb_reg_bus.sv

// File: run_sim.sh
#!/bin/sh
# build the register bus testbench with Verilator, run it and search the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_reg_bus -f verilog.f -o tb_reg_bus \
    && ./obj_dir/tb_reg_bus > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "^No errors$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
